// File: project.f
source/sysinfo_pkg.sv
source/rtc_pkg.sv
source/alarm_cfg_if.sv
source/wb_reg_frontend.sv
source/rtc_core.sv
source/alarm_unit.sv
source/alarm_collector.sv
source/sys_config_top.sv
sim/sys_config_checker.sv
sim/tb_sys_config.sv

// File: sim/sys_config_checker.sv
`timescale 1ns/1ps

module sys_config_checker (
  input logic                  wb_clk_i,
  input logic                  wb_rst_i,
  input logic                  wb_cyc_i,
  input logic                  wb_stb_i,
  input logic                  ack_i,
  input logic                  alarm_i,
  input sysinfo_pkg::cfg_vec_t cfg_vec_i
);

  int unsigned fail_cnt = 0; // assertion failures so far

  // ==================================================
  // wishbone handshake
  // ==================================================
  ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    ack_i |=> !ack_i)
    else begin
      fail_cnt++;
      $error("wb_ack_o high two cycles in a row");
    end

  ack_follows_req: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    $rose(ack_i) |-> $past(wb_cyc_i && wb_stb_i))
    else begin
      fail_cnt++;
      $error("wb_ack_o rose without a request in the cycle before");
    end

  // outputs come out of reset cleared
  reset_values: assert property (@(posedge wb_clk_i)
    $fell(wb_rst_i) |-> (alarm_i == 1'b0 && cfg_vec_i == '0))
    else begin
      fail_cnt++;
      $error("rtc_alarm_o or sys_config_vector_o not zero after reset");
    end

endmodule

bind sys_config_top sys_config_checker checker_i (
  .wb_clk_i  (wb_clk_i),
  .wb_rst_i  (wb_rst_i),
  .wb_cyc_i  (wb_cyc_i),
  .wb_stb_i  (wb_stb_i),
  .ack_i     (wb_ack_o),
  .alarm_i   (rtc_alarm_o),
  .cfg_vec_i (sys_config_vector_o)
);

// File: sim/tb_sys_config.sv
`timescale 1ns/1ps

module tb_sys_config;

  localparam int ACK_LIMIT   = 16;   // bus cycles per transfer
  localparam int POLL_LIMIT  = 40;   // time reads, roughly six seconds at 16 ticks
  localparam int ALARM_LIMIT = 1000; // bus cycles

  logic                  wb_clk_i;
  logic                  wb_rst_i;
  logic                  xtal_clk_i;
  logic                  wb_cyc_i;
  logic                  wb_stb_i;
  logic                  wb_we_i;
  sysinfo_pkg::wb_addr_t wb_adr_i;
  sysinfo_pkg::wb_data_t wb_dat_i;
  sysinfo_pkg::wb_data_t wb_dat_o;
  logic                  wb_ack_o;
  sysinfo_pkg::cfg_vec_t sys_config_vector_o;
  logic                  rtc_alarm_o;

  int seed         = 32'h65bf;
  int check_errors = 0;
  int timeouts     = 0;

  sys_config_top #(
    .TICKS_PER_SEC (16)
  ) sys_config_top_i (.*);

  initial begin
    wb_clk_i = 1'b0;
    forever #5 wb_clk_i = ~wb_clk_i;
  end

  initial begin
    xtal_clk_i = 1'b0;
    forever #35 xtal_clk_i = ~xtal_clk_i; // 70 ns crystal period
  end

  // ==================================================
  // bus and check tasks
  // ==================================================
  task automatic check_value(input string name, input logic [47:0] exp,
                             input logic [47:0] got);
    assert (got === exp) else begin
      check_errors++;
      $display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, exp, got);
    end
  endtask

  task automatic wait_ack();
    int cycles;
    cycles = 0;
    do begin
      @(posedge wb_clk_i);
      cycles++;
    end while (!wb_ack_o && cycles < ACK_LIMIT);
    if (!wb_ack_o) begin
      timeouts++;
      $display("timeout at %0t ns: no wb_ack_o for address %0h", $time, wb_adr_i);
    end
  endtask

  task automatic write_reg(input sysinfo_pkg::wb_addr_t adr,
                           input sysinfo_pkg::wb_data_t dat);
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b1;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wait_ack();
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic read_reg(input sysinfo_pkg::wb_addr_t adr,
                          output sysinfo_pkg::wb_data_t dat);
    @(posedge wb_clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_adr_i <= adr;
    wait_ack();
    dat = wb_dat_o; // held while ack is high
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  task automatic sample_time_words(output rtc_pkg::rtc_time_t t);
    read_reg(sysinfo_pkg::REG_TIME_SEC_2, t[47:32]);
    read_reg(sysinfo_pkg::REG_TIME_SEC_1, t[31:16]);
    read_reg(sysinfo_pkg::REG_TIME_SEC_0, t[15:0]);
  endtask

  // two equal passes in a row, so a carry between words is never seen
  task automatic read_time(output rtc_pkg::rtc_time_t t);
    rtc_pkg::rtc_time_t first;
    rtc_pkg::rtc_time_t second;
    int tries;
    tries = 0;
    do begin
      sample_time_words(first);
      sample_time_words(second);
      tries++;
    end while (first !== second && tries < 4);
    if (first !== second) begin
      timeouts++;
      $display("time words kept changing between reads at %0t ns", $time);
    end
    t = second;
  endtask

  task automatic wait_for_time(input rtc_pkg::rtc_time_t target,
                               output rtc_pkg::rtc_time_t t);
    int polls;
    polls = 0;
    do begin
      read_time(t);
      polls++;
    end while (t !== target && polls < POLL_LIMIT);
    if (t !== target) begin
      timeouts++;
      $display("timeout at %0t ns: time never reached %0h", $time, target);
    end
  endtask

  task automatic wait_time_change(input rtc_pkg::rtc_time_t prev,
                                  output rtc_pkg::rtc_time_t t);
    int polls;
    polls = 0;
    do begin
      read_time(t);
      polls++;
    end while (t === prev && polls < POLL_LIMIT);
    if (t === prev) begin
      timeouts++;
      $display("timeout at %0t ns: time stuck at %0h", $time, prev);
    end
  endtask

  task automatic wait_alarm(input logic level);
    int cycles;
    cycles = 0;
    while (rtc_alarm_o !== level && cycles < ALARM_LIMIT) begin
      @(posedge wb_clk_i);
      cycles++;
    end
    if (rtc_alarm_o !== level) begin
      timeouts++;
      $display("timeout at %0t ns: rtc_alarm_o did not go to %0b", $time, level);
    end
  endtask

  // ==================================================
  // stimulus
  // ==================================================
  initial begin
    sysinfo_pkg::wb_data_t rd;
    sysinfo_pkg::wb_data_t wr;
    rtc_pkg::rtc_time_t    load_t;
    rtc_pkg::rtc_time_t    now_t;
    rtc_pkg::rtc_time_t    prev_t;
    rtc_pkg::alarm_time_t  cmp;
    wb_rst_i = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    repeat (4) @(posedge wb_clk_i);
    wb_rst_i <= 1'b0;

    read_reg(sysinfo_pkg::REG_BOARD_ID, rd);
    check_value("REG_BOARD_ID", sysinfo_pkg::BOARD_ID, rd);
    read_reg(sysinfo_pkg::REG_REV_MAJOR, rd);
    check_value("REG_REV_MAJOR", sysinfo_pkg::REV_MAJOR, rd);
    read_reg(sysinfo_pkg::REG_REV_MINOR, rd);
    check_value("REG_REV_MINOR", sysinfo_pkg::REV_MINOR, rd);
    read_reg(sysinfo_pkg::REG_REV_RCS, rd);
    check_value("REG_REV_RCS", sysinfo_pkg::REV_RCS, rd);
    read_reg(sysinfo_pkg::REG_RCS_UPTODATE, rd);
    check_value("REG_RCS_UPTODATE", sysinfo_pkg::RCS_UPTODATE, rd);
    read_reg(16'h000c, rd);
    check_value("unmapped 0x000c", 48'h0, rd);
    read_reg(sysinfo_pkg::REG_ALARM_BASE, rd); // compare values are write only
    check_value("REG_ALARM_BASE", 48'h0, rd);

    wr = sysinfo_pkg::wb_data_t'($random(seed));
    write_reg(sysinfo_pkg::REG_SYS_CONFIG, wr);
    check_value("sys_config_vector_o", wr[7:0], sys_config_vector_o);
    read_reg(sysinfo_pkg::REG_SYS_CONFIG, rd);
    check_value("REG_SYS_CONFIG", {8'h00, wr[7:0]}, rd);

    // time load and a few seconds of counting
    load_t[47:32] = 16'($random(seed));
    load_t[31:0]  = 32'($random(seed));
    read_time(prev_t); // time before the load
    write_reg(sysinfo_pkg::REG_TIME_SEC_2, load_t[47:32]);
    write_reg(sysinfo_pkg::REG_TIME_SEC_1, load_t[31:16]);
    write_reg(sysinfo_pkg::REG_TIME_SEC_0, load_t[15:0]);
    wait_time_change(prev_t, now_t);
    check_value("time after load", load_t, now_t);
    read_reg(sysinfo_pkg::REG_TIME_TICKER, rd);
    check_value("ticker below 16", 48'h1, rd < 16);

    for (int n = 0; n < rtc_pkg::NUM_ALARMS; n++) begin
      cmp = load_t[31:0] + 32'(2 + n);
      write_reg(sysinfo_pkg::REG_ALARM_BASE + 16'(2 * n), cmp[15:0]);
      write_reg(sysinfo_pkg::REG_ALARM_BASE + 16'(2 * n + 1), cmp[31:16]);
    end
    write_reg(sysinfo_pkg::REG_ALARM_CTRL, 16'h0007); // unit 3 stays disabled
    read_reg(sysinfo_pkg::REG_ALARM_CTRL, rd);
    check_value("REG_ALARM_CTRL", 48'h7, rd);

    prev_t = load_t;
    repeat (3) begin
      wait_time_change(prev_t, now_t);
      check_value("time step", prev_t + 1'b1, now_t);
      prev_t = now_t;
    end

    // alarms fire, then clear in two steps
    wait_alarm(1'b1);
    wait_for_time(load_t + 48'd5, now_t);
    read_reg(sysinfo_pkg::REG_ALARM_STATUS, rd);
    check_value("REG_ALARM_STATUS", 48'h7, rd);
    write_reg(sysinfo_pkg::REG_ALARM_STATUS, 16'h0001);
    read_reg(sysinfo_pkg::REG_ALARM_STATUS, rd);
    check_value("REG_ALARM_STATUS", 48'h6, rd);
    check_value("rtc_alarm_o", 48'h1, rtc_alarm_o);
    write_reg(sysinfo_pkg::REG_ALARM_STATUS, 16'h0006);
    wait_alarm(1'b0);
    read_reg(sysinfo_pkg::REG_ALARM_STATUS, rd);
    check_value("REG_ALARM_STATUS", 48'h0, rd);

    $display("errors: %0d checks, %0d timeouts, %0d assertion failures",
             check_errors, timeouts, sys_config_top_i.checker_i.fail_cnt);
    if (check_errors == 0 && timeouts == 0 && sys_config_top_i.checker_i.fail_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// File: source/alarm_cfg_if.sv
`timescale 1ns/1ps

interface alarm_cfg_if;

  logic                      wr_en;       // one cycle per accepted write
  sysinfo_pkg::wb_addr_t     wr_addr;
  sysinfo_pkg::wb_data_t     wr_data;
  rtc_pkg::alarm_time_t      now_seconds; // from the time snapshot
  wire rtc_pkg::alarm_mask_t hit;         // each unit drives its own bit
  rtc_pkg::alarm_mask_t      pending;

  modport frontend (
    output wr_en,
    output wr_addr,
    output wr_data,
    output now_seconds,
    input  pending
  );

  modport unit (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  now_seconds,
    output hit
  );

  modport collector (
    input  wr_en,
    input  wr_addr,
    input  wr_data,
    input  hit,
    output pending
  );

endinterface

// File: source/alarm_collector.sv
`timescale 1ns/1ps

module alarm_collector (
  input  logic           wb_clk_i,
  input  logic           wb_rst_i,
  alarm_cfg_if.collector cfg,
  output logic           rtc_alarm_o
);

  logic                 sel_status;
  rtc_pkg::alarm_mask_t clr_mask;
  rtc_pkg::alarm_mask_t pending_q;

  assign sel_status = cfg.wr_en && (cfg.wr_addr == sysinfo_pkg::REG_ALARM_STATUS);
  assign clr_mask   = sel_status ? cfg.wr_data[rtc_pkg::NUM_ALARMS-1:0] : '0;

  // ==================================================
  // sticky pending, write one to clear
  // ==================================================
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      pending_q   <= '0;
      rtc_alarm_o <= 1'b0;
    end else begin
      pending_q   <= (pending_q & ~clr_mask) | cfg.hit; // new hit beats clear
      rtc_alarm_o <= |pending_q;
    end
  end

  assign cfg.pending = pending_q;

endmodule

// File: source/alarm_unit.sv
`timescale 1ns/1ps

module alarm_unit #(
  parameter int UNIT_INDEX = 0
) (
  input  logic      wb_clk_i,
  input  logic      wb_rst_i,
  alarm_cfg_if.unit cfg
);

  logic                 sel_lo;
  logic                 sel_hi;
  logic                 sel_ctrl;
  logic                 enable_q;
  logic                 match;
  logic                 prev_match_q;
  rtc_pkg::alarm_time_t cmp_q;

  assign sel_lo = cfg.wr_en && (cfg.wr_addr ==
    sysinfo_pkg::wb_addr_t'(sysinfo_pkg::REG_ALARM_BASE + 2 * UNIT_INDEX));
  assign sel_hi = cfg.wr_en && (cfg.wr_addr ==
    sysinfo_pkg::wb_addr_t'(sysinfo_pkg::REG_ALARM_BASE + 2 * UNIT_INDEX + 1));
  assign sel_ctrl = cfg.wr_en && (cfg.wr_addr == sysinfo_pkg::REG_ALARM_CTRL);

  // compare value, write only
  always_ff @(posedge wb_clk_i) begin
    if (sel_lo) begin
      cmp_q[15:0] <= cfg.wr_data;
    end
    if (sel_hi) begin
      cmp_q[31:16] <= cfg.wr_data;
    end
  end

  assign match = enable_q && (cfg.now_seconds == cmp_q);

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      enable_q     <= 1'b0;
      prev_match_q <= 1'b0;
    end else begin
      if (sel_ctrl) begin
        enable_q <= cfg.wr_data[UNIT_INDEX];
      end
      prev_match_q <= match;
    end
  end

  assign cfg.hit[UNIT_INDEX] = match & ~prev_match_q; // rising edge only

endmodule

// File: source/rtc_core.sv
`timescale 1ns/1ps

module rtc_core #(
  parameter int TICKS_PER_SEC = rtc_pkg::TICKS_PER_SEC
) (
  input  logic               wb_clk_i,
  input  logic               wb_rst_i,
  input  logic               xtal_clk_i,
  input  rtc_pkg::rtc_time_t time_load_i,
  input  logic               load_req_i,
  output logic               load_ack_o,
  output rtc_pkg::rtc_time_t time_snap_o,
  output rtc_pkg::ticker_t   ticker_o
);

  logic [rtc_pkg::RST_STRETCH_W-1:0] rst_cnt_q;
  logic                              xrst_req_q;
  logic [1:0]                        xrst_sync_q;
  logic                              xrst;

  logic [1:0]         req_sync_q;
  logic               req_seen_q; // doubles as the load ack toggle
  logic               load_hit;
  logic               sec_wrap;
  rtc_pkg::rtc_time_t sec_q;
  rtc_pkg::ticker_t   ticker_q;
  rtc_pkg::ticker_t   ticker_nxt;
  rtc_pkg::ticker_t   gray_q;
  logic               snap_tgl_q;

  logic [1:0]       ack_sync_q;
  logic [2:0]       snap_sync_q;
  rtc_pkg::ticker_t gray_meta_q;
  rtc_pkg::ticker_t gray_sync_q;

  // ==================================================
  // reset into the crystal domain
  // ==================================================
  // a bare wb_rst_i pulse can fall between two slow crystal edges
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      rst_cnt_q <= '1;
    end else if (rst_cnt_q != '0) begin
      rst_cnt_q <= rst_cnt_q - 1'b1;
    end
    xrst_req_q <= wb_rst_i | (rst_cnt_q != '0);
  end

  always_ff @(posedge xtal_clk_i) begin
    xrst_sync_q <= {xrst_sync_q[0], xrst_req_q};
  end
  assign xrst = xrst_sync_q[1];

  // ==================================================
  // crystal domain counters
  // ==================================================
  assign load_hit   = req_sync_q[1] ^ req_seen_q;
  assign sec_wrap   = (ticker_q == rtc_pkg::ticker_t'(TICKS_PER_SEC - 1));
  assign ticker_nxt = (load_hit || sec_wrap) ? '0 : ticker_q + 1'b1;

  always_ff @(posedge xtal_clk_i) begin
    if (xrst) begin
      req_sync_q <= '0;
      req_seen_q <= 1'b0;
      sec_q      <= '0;
      ticker_q   <= '0;
      gray_q     <= '0;
      snap_tgl_q <= 1'b0;
    end else begin
      req_sync_q <= {req_sync_q[0], load_req_i};
      ticker_q   <= ticker_nxt;
      gray_q     <= ticker_nxt ^ (ticker_nxt >> 1);
      if (load_hit) begin
        sec_q      <= time_load_i; // stable while the request is open
        req_seen_q <= req_sync_q[1];
        snap_tgl_q <= ~snap_tgl_q;
      end else if (sec_wrap) begin
        sec_q      <= sec_q + 1'b1;
        snap_tgl_q <= ~snap_tgl_q;
      end
    end
  end

  // ==================================================
  // bus domain side
  // ==================================================
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_sync_q  <= '0;
      snap_sync_q <= '0;
      time_snap_o <= '0;
    end else begin
      ack_sync_q  <= {ack_sync_q[0], req_seen_q};
      snap_sync_q <= {snap_sync_q[1:0], snap_tgl_q};
      if (snap_sync_q[2] ^ snap_sync_q[1]) begin
        time_snap_o <= sec_q; // seconds held for a whole second here
      end
    end
  end
  assign load_ack_o = ack_sync_q[1];

  always_ff @(posedge wb_clk_i) begin
    gray_meta_q <= gray_q;
    gray_sync_q <= gray_meta_q;
  end

  always_comb begin
    for (int i = 0; i < rtc_pkg::TICKER_W; i++) begin
      ticker_o[i] = ^(gray_sync_q >> i); // gray to binary
    end
  end

endmodule

// File: source/rtc_pkg.sv
package rtc_pkg;

  // ==================================================
  // time widths and types
  // ==================================================
  localparam int TIME_W   = 48;
  localparam int ALARM_W  = 32;
  localparam int TICKER_W = 15;

  localparam int TICKS_PER_SEC = 32768; // 32.768 kHz crystal
  localparam int NUM_ALARMS    = 4;

  // width of the counter that holds the crystal-domain reset past wb_rst_i
  localparam int RST_STRETCH_W = 4;

  typedef logic [TIME_W-1:0]     rtc_time_t;   // seconds since epoch
  typedef logic [ALARM_W-1:0]    alarm_time_t; // low seconds for compare
  typedef logic [TICKER_W-1:0]   ticker_t;
  typedef logic [NUM_ALARMS-1:0] alarm_mask_t;

endpackage

// File: source/sys_config_top.sv
`timescale 1ns/1ps

module sys_config_top #(
  parameter int TICKS_PER_SEC = rtc_pkg::TICKS_PER_SEC
) (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  sysinfo_pkg::wb_addr_t wb_adr_i,
  input  sysinfo_pkg::wb_data_t wb_dat_i,
  output sysinfo_pkg::wb_data_t wb_dat_o,
  output logic                  wb_ack_o,
  input  logic                  xtal_clk_i,
  output sysinfo_pkg::cfg_vec_t sys_config_vector_o,
  output logic                  rtc_alarm_o
);

  rtc_pkg::rtc_time_t time_load;
  logic               load_req;
  logic               load_ack;
  rtc_pkg::rtc_time_t time_snap;
  rtc_pkg::ticker_t   ticker;

  alarm_cfg_if cfg_bus ();

  wb_reg_frontend frontend_i (
    .wb_clk_i            (wb_clk_i),
    .wb_rst_i            (wb_rst_i),
    .wb_cyc_i            (wb_cyc_i),
    .wb_stb_i            (wb_stb_i),
    .wb_we_i             (wb_we_i),
    .wb_adr_i            (wb_adr_i),
    .wb_dat_i            (wb_dat_i),
    .wb_dat_o            (wb_dat_o),
    .wb_ack_o            (wb_ack_o),
    .sys_config_vector_o (sys_config_vector_o),
    .time_load_o         (time_load),
    .load_req_o          (load_req),
    .load_ack_i          (load_ack),
    .time_snap_i         (time_snap),
    .ticker_i            (ticker),
    .cfg                 (cfg_bus.frontend)
  );

  rtc_core #(
    .TICKS_PER_SEC (TICKS_PER_SEC)
  ) rtc_core_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .xtal_clk_i  (xtal_clk_i),
    .time_load_i (time_load),
    .load_req_i  (load_req),
    .load_ack_o  (load_ack),
    .time_snap_o (time_snap),
    .ticker_o    (ticker)
  );

  for (genvar n = 0; n < rtc_pkg::NUM_ALARMS; n++) begin : g_alarm
    alarm_unit #(
      .UNIT_INDEX (n)
    ) alarm_unit_i (
      .wb_clk_i (wb_clk_i),
      .wb_rst_i (wb_rst_i),
      .cfg      (cfg_bus.unit)
    );
  end

  alarm_collector alarm_collector_i (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .cfg         (cfg_bus.collector),
    .rtc_alarm_o (rtc_alarm_o)
  );

endmodule

// File: source/sysinfo_pkg.sv
package sysinfo_pkg;

  // ==================================================
  // bus widths and types
  // ==================================================
  localparam int DATA_W = 16;
  localparam int ADDR_W = 16;
  localparam int CFG_W  = 8;

  typedef logic [DATA_W-1:0] wb_data_t;
  typedef logic [ADDR_W-1:0] wb_addr_t;
  typedef logic [CFG_W-1:0]  cfg_vec_t;

  // board identification, read only
  localparam wb_data_t BOARD_ID     = 16'h0b41;
  localparam wb_data_t REV_MAJOR    = 16'h0002;
  localparam wb_data_t REV_MINOR    = 16'h0007;
  localparam wb_data_t REV_RCS      = 16'h01c3;
  localparam wb_data_t RCS_UPTODATE = 16'h0001;

  // ==================================================
  // register address map
  // ==================================================
  localparam wb_addr_t REG_BOARD_ID     = 16'h0000;
  localparam wb_addr_t REG_REV_MAJOR    = 16'h0001;
  localparam wb_addr_t REG_REV_MINOR    = 16'h0002;
  localparam wb_addr_t REG_REV_RCS      = 16'h0003;
  localparam wb_addr_t REG_RCS_UPTODATE = 16'h0004;
  localparam wb_addr_t REG_SYS_CONFIG   = 16'h0005;
  localparam wb_addr_t REG_TIME_SEC_2   = 16'h0006; // seconds [47:32]
  localparam wb_addr_t REG_TIME_SEC_1   = 16'h0007; // seconds [31:16]
  localparam wb_addr_t REG_TIME_SEC_0   = 16'h0008; // seconds [15:0], write commits load
  localparam wb_addr_t REG_TIME_TICKER  = 16'h0009;
  localparam wb_addr_t REG_ALARM_CTRL   = 16'h000a; // one enable bit per alarm
  localparam wb_addr_t REG_ALARM_STATUS = 16'h000b; // pending, write one to clear
  localparam wb_addr_t REG_ALARM_BASE   = 16'h0010; // unit n: lo at +2n, hi at +2n+1

endpackage

// File: source/wb_reg_frontend.sv
`timescale 1ns/1ps

module wb_reg_frontend (
  input  logic                   wb_clk_i,
  input  logic                   wb_rst_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  sysinfo_pkg::wb_addr_t  wb_adr_i,
  input  sysinfo_pkg::wb_data_t  wb_dat_i,
  output sysinfo_pkg::wb_data_t  wb_dat_o,
  output logic                   wb_ack_o,
  output sysinfo_pkg::cfg_vec_t  sys_config_vector_o,
  output rtc_pkg::rtc_time_t     time_load_o,
  output logic                   load_req_o,
  input  logic                   load_ack_i,
  input  rtc_pkg::rtc_time_t     time_snap_i,
  input  rtc_pkg::ticker_t       ticker_i,
  alarm_cfg_if.frontend          cfg
);

  logic                  accept;
  logic                  wr_acc;
  logic                  load_busy;
  sysinfo_pkg::wb_data_t rd_data;
  rtc_pkg::alarm_mask_t  alarm_en_q;
  logic [31:0]           time_buf_hi; // seconds [47:16] waiting for the low word

  assign accept    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_acc    = accept & wb_we_i;
  assign load_busy = load_req_o ^ load_ack_i; // previous load not yet taken

  assign cfg.wr_en       = wr_acc;
  assign cfg.wr_addr     = wb_adr_i;
  assign cfg.wr_data     = wb_dat_i;
  assign cfg.now_seconds = time_snap_i[rtc_pkg::ALARM_W-1:0];

  // ==================================================
  // read mux
  // ==================================================
  always_comb begin
    rd_data = '0; // unmapped and write-only addresses
    case (wb_adr_i)
      sysinfo_pkg::REG_BOARD_ID:     rd_data = sysinfo_pkg::BOARD_ID;
      sysinfo_pkg::REG_REV_MAJOR:    rd_data = sysinfo_pkg::REV_MAJOR;
      sysinfo_pkg::REG_REV_MINOR:    rd_data = sysinfo_pkg::REV_MINOR;
      sysinfo_pkg::REG_REV_RCS:      rd_data = sysinfo_pkg::REV_RCS;
      sysinfo_pkg::REG_RCS_UPTODATE: rd_data = sysinfo_pkg::RCS_UPTODATE;
      sysinfo_pkg::REG_SYS_CONFIG:   rd_data = sysinfo_pkg::wb_data_t'(sys_config_vector_o);
      sysinfo_pkg::REG_TIME_SEC_2:   rd_data = time_snap_i[47:32];
      sysinfo_pkg::REG_TIME_SEC_1:   rd_data = time_snap_i[31:16];
      sysinfo_pkg::REG_TIME_SEC_0:   rd_data = time_snap_i[15:0];
      sysinfo_pkg::REG_TIME_TICKER:  rd_data = sysinfo_pkg::wb_data_t'(ticker_i);
      sysinfo_pkg::REG_ALARM_CTRL:   rd_data = sysinfo_pkg::wb_data_t'(alarm_en_q);
      sysinfo_pkg::REG_ALARM_STATUS: rd_data = sysinfo_pkg::wb_data_t'(cfg.pending);
      default:                       rd_data = '0;
    endcase
  end

  // ==================================================
  // control registers
  // ==================================================
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o            <= 1'b0;
      sys_config_vector_o <= '0;
      alarm_en_q          <= '0;
      load_req_o          <= 1'b0;
    end else begin
      wb_ack_o <= accept; // single cycle, never back to back
      if (wr_acc) begin
        case (wb_adr_i)
          sysinfo_pkg::REG_SYS_CONFIG: sys_config_vector_o <= wb_dat_i[sysinfo_pkg::CFG_W-1:0];
          sysinfo_pkg::REG_ALARM_CTRL: alarm_en_q <= wb_dat_i[rtc_pkg::NUM_ALARMS-1:0];
          sysinfo_pkg::REG_TIME_SEC_0: begin
            if (!load_busy) begin
              load_req_o <= ~load_req_o; // toggle request to the crystal domain
            end
          end
          default: ;
        endcase
      end
    end
  end

  // read data and time load buffer
  always_ff @(posedge wb_clk_i) begin
    if (accept) begin
      wb_dat_o <= rd_data;
    end
    if (wr_acc) begin
      case (wb_adr_i)
        sysinfo_pkg::REG_TIME_SEC_2: time_buf_hi[31:16] <= wb_dat_i;
        sysinfo_pkg::REG_TIME_SEC_1: time_buf_hi[15:0]  <= wb_dat_i;
        sysinfo_pkg::REG_TIME_SEC_0: begin
          if (!load_busy) begin
            time_load_o <= {time_buf_hi, wb_dat_i}; // held until acked
          end
        end
        default: ;
      endcase
    end
  end

endmodule
